/* Makefile */
TOP := tb_router

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

/* src/ahb_router_top.sv */
`default_nettype none

module ahb_router_top import router_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   reset,
    // imem master
    input  wire logic [ADDR_W-1:0]      imem_haddr,
    input  wire logic [DATA_W-1:0]      imem_hwdata,
    input  wire logic                   imem_hwrite,
    input  wire logic [2:0]             imem_hsize,
    input  wire logic [1:0]             imem_htrans,
    output logic                        imem_hready,
    output logic [DATA_W-1:0]           imem_hrdata,
    // dmem master
    input  wire logic [ADDR_W-1:0]      dmem_haddr,
    input  wire logic [DATA_W-1:0]      dmem_hwdata,
    input  wire logic                   dmem_hwrite,
    input  wire logic [2:0]             dmem_hsize,
    input  wire logic [1:0]             dmem_htrans,
    output logic                        dmem_hready,
    output logic [DATA_W-1:0]           dmem_hrdata,
    // Instruction RAM
    input  wire logic [DATA_W-1:0]      inst_read,
    output logic [DATA_W-1:0]           inst_write,
    output logic [WORD_ADDR_W-1:0]      inst_addr,
    output logic [LANES-1:0]            inst_wben,
    output logic                        inst_rwn,
    // Data RAM
    input  wire logic [DATA_W-1:0]      data_read,
    output logic [DATA_W-1:0]           data_write,
    output logic [WORD_ADDR_W-1:0]      data_addr,
    output logic [LANES-1:0]            data_wben,
    output logic                        data_rwn,
    // Register block
    input  wire logic [DATA_W-1:0]      reg_read,
    output logic [DATA_W-1:0]           reg_write,
    output logic [REG_ADDR_W-1:0]       reg_addr,
    output logic [LANES-1:0]            reg_wben,
    output logic                        reg_rwn
);

    target_req_if imem_req ();
    target_req_if dmem_req ();

    logic                   inst_imem_grant, inst_dmem_grant;
    logic                   data_imem_grant, data_dmem_grant;
    logic                   reg_imem_grant, reg_dmem_grant;
    logic [WORD_ADDR_W-1:0] reg_word_addr;

    ////////////////////////////////////////////////////////////
    // Decoders
    ////////////////////////////////////////////////////////////
    master_decoder u_imem_dec (
        .haddr  (imem_haddr),
        .hwrite (imem_hwrite),
        .hsize  (hsize_e'(imem_hsize)),
        .htrans (htrans_e'(imem_htrans)),
        .hwdata (imem_hwdata),
        .req    (imem_req)
    );

    master_decoder u_dmem_dec (
        .haddr  (dmem_haddr),
        .hwrite (dmem_hwrite),
        .hsize  (hsize_e'(dmem_hsize)),
        .htrans (htrans_e'(dmem_htrans)),
        .hwdata (dmem_hwdata),
        .req    (dmem_req)
    );

    ////////////////////////////////////////////////////////////
    // One arbiter per target
    ////////////////////////////////////////////////////////////
    target_arbiter #(.TARGET(TGT_INST), .FIRST_FAVOR(INST_FAVOR_INIT)) u_inst_arb (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .imem_grant (inst_imem_grant),
        .dmem_grant (inst_dmem_grant),
        .t_write    (inst_write),
        .t_addr     (inst_addr),
        .t_wben     (inst_wben),
        .t_rwn      (inst_rwn)
    );

    target_arbiter #(.TARGET(TGT_DATA), .FIRST_FAVOR(DATA_FAVOR_INIT)) u_data_arb (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .imem_grant (data_imem_grant),
        .dmem_grant (data_dmem_grant),
        .t_write    (data_write),
        .t_addr     (data_addr),
        .t_wben     (data_wben),
        .t_rwn      (data_rwn)
    );

    target_arbiter #(.TARGET(TGT_REG), .FIRST_FAVOR(REG_FAVOR_INIT)) u_reg_arb (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .imem_grant (reg_imem_grant),
        .dmem_grant (reg_dmem_grant),
        .t_write    (reg_write),
        .t_addr     (reg_word_addr),
        .t_wben     (reg_wben),
        .t_rwn      (reg_rwn)
    );

    // Register block only sees the low address bits
    assign reg_addr = reg_word_addr[REG_ADDR_W-1:0];

    ////////////////////////////////////////////////////////////
    // Responses back to the masters
    ////////////////////////////////////////////////////////////
    master_response u_imem_rsp (
        .clk        (clk),
        .reset      (reset),
        .requested  (imem_req.valid),
        .grant_inst (inst_imem_grant),
        .grant_data (data_imem_grant),
        .grant_reg  (reg_imem_grant),
        .inst_read  (inst_read),
        .data_read  (data_read),
        .reg_read   (reg_read),
        .hready     (imem_hready),
        .hrdata     (imem_hrdata)
    );

    master_response u_dmem_rsp (
        .clk        (clk),
        .reset      (reset),
        .requested  (dmem_req.valid),
        .grant_inst (inst_dmem_grant),
        .grant_data (data_dmem_grant),
        .grant_reg  (reg_dmem_grant),
        .inst_read  (inst_read),
        .data_read  (data_read),
        .reg_read   (reg_read),
        .hready     (dmem_hready),
        .hrdata     (dmem_hrdata)
    );

endmodule

`default_nettype wire

/* src/master_decoder.sv */
`default_nettype none

module master_decoder import router_pkg::*; (
    input  wire logic [ADDR_W-1:0] haddr,
    input  wire logic              hwrite,
    input  wire hsize_e            hsize,
    input  wire htrans_e           htrans,
    input  wire logic [DATA_W-1:0] hwdata,
    target_req_if.decoder          req
);

    // Only NONSEQ starts a transfer; SEQ and BUSY are ignored
    assign req.valid = (htrans == NONSEQ);
    assign req.wdata = hwdata;
    assign req.rwn   = ~hwrite;

    always_comb begin
        if (haddr[REG_SEL_BIT]) begin
            req.target = TGT_REG;
        end else if (haddr[DATA_SEL_BIT]) begin
            req.target = TGT_DATA;
        end else begin
            req.target = TGT_INST;
        end
    end

    always_comb begin
        if (haddr[REG_SEL_BIT]) begin
            req.word_addr = {{(WORD_ADDR_W-REG_ADDR_W){1'b0}}, haddr[REG_ADDR_W-1:0]};
        end else begin
            req.word_addr = haddr[WORD_ADDR_W+1:2];
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte lanes from size and low address bits
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (hsize)
            SIZE_BYTE: begin
                req.wben = LANES'(1) << haddr[1:0];
            end
            SIZE_HALF: begin
                if (haddr[1:0] == 2'b00) begin
                    req.wben = 4'b0011;
                end else begin
                    req.wben = 4'b1100;
                end
            end
            default: begin
                req.wben = '1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/master_response.sv */
`default_nettype none

module master_response import router_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              requested,
    input  wire logic              grant_inst,
    input  wire logic              grant_data,
    input  wire logic              grant_reg,
    input  wire logic [DATA_W-1:0] inst_read,
    input  wire logic [DATA_W-1:0] data_read,
    input  wire logic [DATA_W-1:0] reg_read,
    output logic                   hready,
    output logic [DATA_W-1:0]      hrdata
);

    logic granted;

    assign granted = grant_inst || grant_data || grant_reg;

    // Lost arbitration means one wait cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            hready <= 1'b0;
        end else begin
            hready <= !(requested && !granted);
        end
    end

    // At most one grant per master
    always_ff @(posedge clk) begin
        if (grant_inst) begin
            hrdata <= inst_read;
        end else if (grant_data) begin
            hrdata <= data_read;
        end else if (grant_reg) begin
            hrdata <= reg_read;
        end
    end

endmodule

`default_nettype wire

/* src/router_pkg.sv */
`default_nettype none

package router_pkg;

    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int WORD_ADDR_W = 12;
    localparam int REG_ADDR_W  = 3;
    localparam int LANES       = 4;

    // Address bits that pick the target
    localparam int REG_SEL_BIT  = 15;
    localparam int DATA_SEL_BIT = 14;

    typedef enum logic [1:0] {
        TGT_INST,
        TGT_DATA,
        TGT_REG
    } target_e;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        NONSEQ,
        SEQ
    } htrans_e;

    typedef enum logic [2:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } hsize_e;

    typedef enum logic {
        MST_IMEM,
        MST_DMEM
    } master_e;

    // Favor after reset for each target
    localparam master_e INST_FAVOR_INIT = MST_IMEM;
    localparam master_e DATA_FAVOR_INIT = MST_DMEM;
    localparam master_e REG_FAVOR_INIT  = MST_DMEM;

endpackage

`default_nettype wire

/* src/target_arbiter.sv */
`default_nettype none

module target_arbiter import router_pkg::*; #(
    parameter target_e TARGET      = TGT_INST,
    parameter master_e FIRST_FAVOR = MST_IMEM
) (
    input  wire logic              clk,
    input  wire logic              reset,
    target_req_if.arbiter          imem_req,
    target_req_if.arbiter          dmem_req,
    output logic                   imem_grant,
    output logic                   dmem_grant,
    output logic [DATA_W-1:0]      t_write,
    output logic [WORD_ADDR_W-1:0] t_addr,
    output logic [LANES-1:0]       t_wben,
    output logic                   t_rwn
);

    logic    imem_hit;
    logic    dmem_hit;
    master_e favor;

    assign imem_hit = imem_req.valid && (imem_req.target == TARGET);
    assign dmem_hit = dmem_req.valid && (dmem_req.target == TARGET);

    // Favored master wins a collision
    assign imem_grant = imem_hit && (!dmem_hit || favor == MST_IMEM);
    assign dmem_grant = dmem_hit && (!imem_hit || favor == MST_DMEM);

    always_ff @(posedge clk) begin
        if (reset) begin
            favor <= FIRST_FAVOR;
        end else if (imem_hit && dmem_hit) begin
            favor <= (favor == MST_IMEM) ? MST_DMEM : MST_IMEM;
        end
    end

    ////////////////////////////////////////////////////////////
    // Target outputs hold when nothing is granted
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (imem_grant) begin
            t_write <= imem_req.wdata;
            t_addr  <= imem_req.word_addr;
            t_wben  <= imem_req.wben;
            t_rwn   <= imem_req.rwn;
        end else if (dmem_grant) begin
            t_write <= dmem_req.wdata;
            t_addr  <= dmem_req.word_addr;
            t_wben  <= dmem_req.wben;
            t_rwn   <= dmem_req.rwn;
        end
    end

endmodule

`default_nettype wire

/* src/target_req_if.sv */
`default_nettype none

interface target_req_if import router_pkg::*; ();

    logic                   valid;
    target_e                target;
    logic [WORD_ADDR_W-1:0] word_addr;
    logic [DATA_W-1:0]      wdata;
    logic                   rwn;
    logic [LANES-1:0]       wben;

    modport decoder (
        output valid,
        output target,
        output word_addr,
        output wdata,
        output rwn,
        output wben
    );

    modport arbiter (
        input valid,
        input target,
        input word_addr,
        input wdata,
        input rwn,
        input wben
    );

endinterface

`default_nettype wire

/* tb.f */
src/router_pkg.sv
src/target_req_if.sv
src/master_decoder.sv
src/target_arbiter.sv
src/master_response.sv
src/ahb_router_top.sv
verification/router_props.sv
verification/tb_router.sv

/* verification/router_props.sv */
`default_nettype none

module router_props import router_pkg::*; (
    input wire logic              clk,
    input wire logic              reset,
    input wire logic [ADDR_W-1:0] imem_haddr,
    input wire logic [1:0]        imem_htrans,
    input wire logic              imem_hready,
    input wire logic [ADDR_W-1:0] dmem_haddr,
    input wire logic [1:0]        dmem_htrans,
    input wire logic              dmem_hready,
    input wire logic [LANES-1:0]  inst_wben,
    input wire logic [LANES-1:0]  data_wben,
    input wire logic [LANES-1:0]  reg_wben
);

    timeunit 1ns;
    timeprecision 1ps;

    logic imem_go;
    logic dmem_go;
    logic collide;
    logic inst_hit;
    logic data_hit;
    logic reg_hit;

    function automatic target_e route(input logic [ADDR_W-1:0] a);
        if (a[REG_SEL_BIT]) begin
            return TGT_REG;
        end else if (a[DATA_SEL_BIT]) begin
            return TGT_DATA;
        end else begin
            return TGT_INST;
        end
    endfunction

    // Byte, half or word patterns
    function automatic logic legal_lanes(input logic [LANES-1:0] wben);
        return $onehot(wben) || wben == 4'b0011 || wben == 4'b1100 || wben == 4'b1111;
    endfunction

    assign imem_go  = (imem_htrans == NONSEQ);
    assign dmem_go  = (dmem_htrans == NONSEQ);
    assign collide  = imem_go && dmem_go && (route(imem_haddr) == route(dmem_haddr));
    assign inst_hit = (imem_go && route(imem_haddr) == TGT_INST)
                   || (dmem_go && route(dmem_haddr) == TGT_INST);
    assign data_hit = (imem_go && route(imem_haddr) == TGT_DATA)
                   || (dmem_go && route(dmem_haddr) == TGT_DATA);
    assign reg_hit  = (imem_go && route(imem_haddr) == TGT_REG)
                   || (dmem_go && route(dmem_haddr) == TGT_REG);

    ready_after_reset: assert property (@(posedge clk) reset |=> !imem_hready && !dmem_hready)
        else $error("hready high in the cycle after reset");

    one_winner: assert property (@(posedge clk) disable iff (reset)
        collide |=> (imem_hready ^ dmem_hready))
        else $error("collision did not give exactly one hready");

    inst_lanes: assert property (@(posedge clk) disable iff (reset)
        inst_hit |=> legal_lanes(inst_wben))
        else $error("illegal inst_wben pattern");

    data_lanes: assert property (@(posedge clk) disable iff (reset)
        data_hit |=> legal_lanes(data_wben))
        else $error("illegal data_wben pattern");

    reg_lanes: assert property (@(posedge clk) disable iff (reset)
        reg_hit |=> legal_lanes(reg_wben))
        else $error("illegal reg_wben pattern");

endmodule

bind ahb_router_top router_props u_props (
    .clk         (clk),
    .reset       (reset),
    .imem_haddr  (imem_haddr),
    .imem_htrans (imem_htrans),
    .imem_hready (imem_hready),
    .dmem_haddr  (dmem_haddr),
    .dmem_htrans (dmem_htrans),
    .dmem_hready (dmem_hready),
    .inst_wben   (inst_wben),
    .data_wben   (data_wben),
    .reg_wben    (reg_wben)
);

`default_nettype wire

/* verification/tb_router.sv */
`default_nettype none

module tb_router import router_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        htrans_e                trans;
        hsize_e                 size;
        logic                   write;
        logic [ADDR_W-1:0]      addr;
        logic [DATA_W-1:0]      wdata;
        // Expected decode worked out by hand
        logic [WORD_ADDR_W-1:0] waddr;
        logic [LANES-1:0]       wben;
    } mreq_t;

    typedef struct packed {
        mreq_t             im;
        mreq_t             dm;
        logic [DATA_W-1:0] inst_rd;
        logic [DATA_W-1:0] data_rd;
        logic [DATA_W-1:0] reg_rd;
        logic [1:0]        rdy;
    } row_t;

    typedef struct packed {
        logic                   known;
        logic [DATA_W-1:0]      write;
        logic [WORD_ADDR_W-1:0] addr;
        logic [LANES-1:0]       wben;
        logic                   rwn;
    } tstate_t;

    logic                   clk;
    logic                   reset;
    logic [ADDR_W-1:0]      imem_haddr, dmem_haddr;
    logic [DATA_W-1:0]      imem_hwdata, dmem_hwdata;
    logic                   imem_hwrite, dmem_hwrite;
    hsize_e                 imem_hsize, dmem_hsize;
    htrans_e                imem_htrans, dmem_htrans;
    logic                   imem_hready, dmem_hready;
    logic [DATA_W-1:0]      imem_hrdata, dmem_hrdata;
    logic [DATA_W-1:0]      inst_read, data_read, reg_read;
    logic [DATA_W-1:0]      inst_write, data_write, reg_write;
    logic [WORD_ADDR_W-1:0] inst_addr, data_addr;
    logic [REG_ADDR_W-1:0]  reg_addr;
    logic [LANES-1:0]       inst_wben, data_wben, reg_wben;
    logic                   inst_rwn, data_rwn, reg_rwn;

    row_t              rows [$];
    string             names [$];
    // One owner letter per target (inst data reg) with - for held
    string             owners [$];
    tstate_t           inst_exp, data_exp, reg_exp;
    logic [DATA_W-1:0] imem_rd, dmem_rd;
    logic              imem_rd_known = 1'b0;
    logic              dmem_rd_known = 1'b0;
    int                seed = 32'h6e89;
    int                cycle_count = 0;

    ahb_router_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > 16 + rows.size() + 20) begin
            stop_on_error("Timeout: the stimulus table did not finish in time");
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_ready(input string test, input string port, input logic exp,
                               input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error: %s %s_hready: expected %b, actual %b",
                                    test, port, exp, act));
        end
    endtask

    task automatic check_rdata(input string test, input string port,
                               input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error: %s %s_hrdata: expected %h, actual %h",
                                    test, port, exp, act));
        end
    endtask

    task automatic check_target(input string test, input string tgt, input tstate_t exp,
                                input logic [DATA_W-1:0] write,
                                input logic [WORD_ADDR_W-1:0] addr,
                                input logic [LANES-1:0] wben, input logic rwn);
        if (write !== exp.write) begin
            stop_on_error($sformatf("Error: %s %s_write: expected %h, actual %h",
                                    test, tgt, exp.write, write));
        end
        if (addr !== exp.addr) begin
            stop_on_error($sformatf("Error: %s %s_addr: expected %h, actual %h",
                                    test, tgt, exp.addr, addr));
        end
        if (wben !== exp.wben) begin
            stop_on_error($sformatf("Error: %s %s_wben: expected %b, actual %b",
                                    test, tgt, exp.wben, wben));
        end
        if (rwn !== exp.rwn) begin
            stop_on_error($sformatf("Error: %s %s_rwn: expected %b, actual %b",
                                    test, tgt, exp.rwn, rwn));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Table building and expected state
    ////////////////////////////////////////////////////////////
    function automatic mreq_t mreq(input htrans_e trans, input hsize_e size, input logic write,
                                   input logic [ADDR_W-1:0] addr,
                                   input logic [WORD_ADDR_W-1:0] waddr,
                                   input logic [LANES-1:0] wben);
        mreq_t m;
        m.trans = trans;
        m.size  = size;
        m.write = write;
        m.addr  = addr;
        m.wdata = '0;
        m.waddr = waddr;
        m.wben  = wben;
        return m;
    endfunction

    function automatic mreq_t no_req(input htrans_e trans);
        return mreq(trans, SIZE_WORD, 1'b0, '0, '0, '0);
    endfunction

    task automatic add_row(input string name, input string own, input logic [1:0] rdy,
                           input mreq_t im, input mreq_t dm);
        row_t r;
        r.im       = im;
        r.dm       = dm;
        r.im.wdata = $random(seed);
        r.dm.wdata = $random(seed);
        r.inst_rd  = $random(seed);
        r.data_rd  = $random(seed);
        r.reg_rd   = $random(seed);
        r.rdy      = rdy;
        rows.push_back(r);
        names.push_back(name);
        owners.push_back(own);
    endtask

    task automatic build_table();
        // rdy is {imem, dmem}
        add_row("dec_inst_i", "I--", 2'b11,
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_0124, 12'h049, 4'hf), no_req(IDLE));
        add_row("dec_data_d", "-D-", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_4038, 12'h00e, 4'hf));
        add_row("dec_reg_d", "--D", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_8004, 12'h004, 4'hf));
        add_row("dec_reg_i_1x", "--I", 2'b11,
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_c00c, 12'h004, 4'hf), no_req(IDLE));
        add_row("dec_data_i", "-I-", 2'b11,
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_7ff0, 12'hffc, 4'hf), no_req(IDLE));
        add_row("dec_inst_d", "D--", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_3ffc, 12'hfff, 4'hf));
        add_row("lane_byte0", "-D-", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_BYTE, 1'b1, 32'h0000_4100, 12'h040, 4'b0001));
        add_row("lane_byte1", "-D-", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_BYTE, 1'b1, 32'h0000_4101, 12'h040, 4'b0010));
        add_row("lane_byte2", "-D-", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_BYTE, 1'b1, 32'h0000_4102, 12'h040, 4'b0100));
        add_row("lane_byte3", "-D-", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_BYTE, 1'b1, 32'h0000_4103, 12'h040, 4'b1000));
        add_row("lane_half0", "-D-", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_HALF, 1'b1, 32'h0000_4104, 12'h041, 4'b0011));
        add_row("lane_half2", "-D-", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_HALF, 1'b1, 32'h0000_4106, 12'h041, 4'b1100));
        // Collisions; inst starts with imem, data and reg with dmem
        add_row("arb_inst_1", "I--", 2'b10,
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_0010, 12'h004, 4'hf),
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_0020, 12'h008, 4'hf));
        add_row("arb_inst_2", "D--", 2'b01,
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_0010, 12'h004, 4'hf),
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_0020, 12'h008, 4'hf));
        add_row("arb_inst_3", "I--", 2'b10,
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_0010, 12'h004, 4'hf),
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_0020, 12'h008, 4'hf));
        add_row("arb_data_1", "-D-", 2'b01,
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_4010, 12'h004, 4'hf),
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_4020, 12'h008, 4'hf));
        add_row("arb_data_2", "-I-", 2'b10,
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_4010, 12'h004, 4'hf),
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_4020, 12'h008, 4'hf));
        add_row("arb_reg_1", "--D", 2'b01,
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_8001, 12'h001, 4'hf),
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_8002, 12'h002, 4'hf));
        add_row("arb_reg_2", "--I", 2'b10,
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_8001, 12'h001, 4'hf),
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_8002, 12'h002, 4'hf));
        add_row("par_inst_data", "ID-", 2'b11,
                mreq(NONSEQ, SIZE_WORD, 1'b0, 32'h0000_0040, 12'h010, 4'hf),
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_4080, 12'h020, 4'hf));
        add_row("par_reg_inst", "D-I", 2'b11,
                mreq(NONSEQ, SIZE_BYTE, 1'b0, 32'h0000_8007, 12'h007, 4'b1000),
                mreq(NONSEQ, SIZE_WORD, 1'b1, 32'h0000_0100, 12'h040, 4'hf));
        add_row("idle_seq", "---", 2'b11, no_req(SEQ), no_req(IDLE));
        add_row("idle_both", "---", 2'b11, no_req(IDLE), no_req(SEQ));
        add_row("read_data_half", "-D-", 2'b11,
                no_req(IDLE), mreq(NONSEQ, SIZE_HALF, 1'b0, 32'h0000_4ffe, 12'h3ff, 4'b1100));
    endtask

    function automatic tstate_t granted_output(input tstate_t cur, input byte who,
                                               input row_t r);
        mreq_t   m;
        tstate_t upd;
        if (who == "-") begin
            return cur;
        end
        m         = (who == "I") ? r.im : r.dm;
        upd.known = 1'b1;
        upd.write = m.wdata;
        upd.addr  = m.waddr;
        upd.wben  = m.wben;
        upd.rwn   = !m.write;
        return upd;
    endfunction

    task automatic track_rdata(input byte who, input logic [DATA_W-1:0] rd);
        if (who == "I") begin
            imem_rd       = rd;
            imem_rd_known = 1'b1;
        end else if (who == "D") begin
            dmem_rd       = rd;
            dmem_rd_known = 1'b1;
        end
    endtask

    task automatic apply(input row_t r);
        imem_haddr  = r.im.addr;
        imem_hwdata = r.im.wdata;
        imem_hwrite = r.im.write;
        imem_hsize  = r.im.size;
        imem_htrans = r.im.trans;
        dmem_haddr  = r.dm.addr;
        dmem_hwdata = r.dm.wdata;
        dmem_hwrite = r.dm.write;
        dmem_hsize  = r.dm.size;
        dmem_htrans = r.dm.trans;
        inst_read   = r.inst_rd;
        data_read   = r.data_rd;
        reg_read    = r.reg_rd;
    endtask

    task automatic check_row(input int k);
        row_t  r;
        string own;
        string name;
        r        = rows[k];
        own      = owners[k];
        name     = names[k];
        inst_exp = granted_output(inst_exp, own[0], r);
        data_exp = granted_output(data_exp, own[1], r);
        reg_exp  = granted_output(reg_exp, own[2], r);
        track_rdata(own[0], r.inst_rd);
        track_rdata(own[1], r.data_rd);
        track_rdata(own[2], r.reg_rd);
        check_ready(name, "imem", r.rdy[1], imem_hready);
        check_ready(name, "dmem", r.rdy[0], dmem_hready);
        if (imem_rd_known) begin
            check_rdata(name, "imem", imem_rd, imem_hrdata);
        end
        if (dmem_rd_known) begin
            check_rdata(name, "dmem", dmem_rd, dmem_hrdata);
        end
        // Target outputs are unknown until first granted
        if (inst_exp.known) begin
            check_target(name, "inst", inst_exp, inst_write, inst_addr, inst_wben, inst_rwn);
        end
        if (data_exp.known) begin
            check_target(name, "data", data_exp, data_write, data_addr, data_wben, data_rwn);
        end
        if (reg_exp.known) begin
            check_target(name, "reg", reg_exp, reg_write,
                         {{(WORD_ADDR_W-REG_ADDR_W){1'b0}}, reg_addr}, reg_wben, reg_rwn);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        apply('0);
        reset    = 1'b1;
        inst_exp = '0;
        data_exp = '0;
        reg_exp  = '0;
        build_table();
        repeat (16) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset = 1'b0;
        check_ready("after_reset", "imem", 1'b0, imem_hready);
        check_ready("after_reset", "dmem", 1'b0, dmem_hready);
        for (int k = 0; k < rows.size(); k++) begin
            apply(rows[k]);
            @(negedge clk);
            check_row(k);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
